// File: Bender.yml
package:
  name: sap1_cpu

sources:
  - include_dirs:
      - include
    files:
      - src/cpu_isa_pkg.sv
      - src/cpu_ctrl_pkg.sv
      - src/program_counter.sv
      - src/control_block.sv
      - src/alu.sv
      - src/data_register.sv
      - src/ram_mar.sv
      - src/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/cpu_tb.sv

// File: include/cpu_params.svh
// width and sizing macros for the accumulator cpu
// include wherever a width, the ram depth or the t-state count is needed
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and bus width
`define CPU_DATA_W 8

// program counter and ram address width
`define CPU_ADDR_W 4

// bytes of ram, one per address
`define CPU_RAM_DEPTH 16

// fixed instruction length, fetch plus execute
`define CPU_T_STATES 6

`endif

// File: src/alu.sv
// adder and subtractor over the accumulator and b register
// result is combinational, carry and zero are held until the next flags_load
`include "cpu_params.svh"

module alu (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_isa_pkg::byte_t a,
    input  cpu_isa_pkg::byte_t b,
    input  logic               sub,
    input  logic               flags_load,
    output cpu_isa_pkg::byte_t result,
    output logic               carry,
    output logic               zero
);

    cpu_isa_pkg::byte_t    b_op;
    logic [`CPU_DATA_W:0]  sum;

    // subtract as a plus inverted b plus one
    assign b_op = sub ? ~b : b;

    // extra top bit is the carry out
    // for sub it is set when there is no borrow, a >= b
    assign sum    = {1'b0, a} + {1'b0, b_op} + {{`CPU_DATA_W{1'b0}}, sub};
    assign result = sum[`CPU_DATA_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (flags_load) begin
            carry <= sum[`CPU_DATA_W];
            // zero looks at the 8-bit result only
            zero  <= (result == '0);
        end
    end

endmodule

// File: src/control_block.sv
// microcoded control of the accumulator cpu
// t-state ring plus decoder from opcode and flags to the control word
// ring runs while run is high and the cpu has not halted
`include "cpu_params.svh"

module control_block (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     run,
    input  cpu_isa_pkg::opcode_e     opcode,
    input  logic                     carry,
    input  logic                     zero,
    output cpu_ctrl_pkg::ctrl_word_t ctrl,
    output logic                     halted
);

    cpu_ctrl_pkg::tstate_t tstate;
    logic                  active;

    // nothing moves while stopped or halted
    assign active = run && !halted;

    // one-hot ring, rotates once per active cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tstate <= cpu_ctrl_pkg::T0;
        end else if (active) begin
            tstate <= cpu_ctrl_pkg::tstate_t'(
                {tstate[`CPU_T_STATES-2:0], tstate[`CPU_T_STATES-1]});
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    // microcode table
    always_comb begin
        ctrl         = '0;
        ctrl.bus_src = cpu_ctrl_pkg::NONE;
        if (active) begin
            case (tstate)
                // fetch, same for every opcode
                cpu_ctrl_pkg::T0: begin
                    ctrl.bus_src  = cpu_ctrl_pkg::PC;
                    ctrl.mar_load = 1'b1;
                end
                cpu_ctrl_pkg::T1: ctrl.pc_count = 1'b1;
                cpu_ctrl_pkg::T2: begin
                    ctrl.bus_src = cpu_ctrl_pkg::RAM;
                    ctrl.ir_load = 1'b1;
                end
                // execute
                cpu_ctrl_pkg::T3: begin
                    case (opcode)
                        cpu_isa_pkg::LDA, cpu_isa_pkg::ADD,
                        cpu_isa_pkg::SUB, cpu_isa_pkg::STA: begin
                            // operand addresses ram
                            ctrl.bus_src  = cpu_ctrl_pkg::IR_OPERAND;
                            ctrl.mar_load = 1'b1;
                        end
                        cpu_isa_pkg::LDI: begin
                            ctrl.bus_src = cpu_ctrl_pkg::IR_OPERAND;
                            ctrl.a_load  = 1'b1;
                        end
                        cpu_isa_pkg::JMP, cpu_isa_pkg::JC, cpu_isa_pkg::JZ: begin
                            ctrl.bus_src = cpu_ctrl_pkg::IR_OPERAND;
                            // branch decision lives here only
                            ctrl.pc_load = (opcode == cpu_isa_pkg::JMP) ||
                                           (opcode == cpu_isa_pkg::JC && carry) ||
                                           (opcode == cpu_isa_pkg::JZ && zero);
                        end
                        cpu_isa_pkg::OUT: begin
                            ctrl.bus_src  = cpu_ctrl_pkg::ACC;
                            ctrl.out_load = 1'b1;
                        end
                        cpu_isa_pkg::HLT: ctrl.halt = 1'b1;
                        default: ;
                    endcase
                end
                cpu_ctrl_pkg::T4: begin
                    ctrl.bus_src = cpu_ctrl_pkg::RAM;
                    case (opcode)
                        cpu_isa_pkg::LDA: ctrl.a_load = 1'b1;
                        cpu_isa_pkg::ADD, cpu_isa_pkg::SUB: ctrl.b_load = 1'b1;
                        cpu_isa_pkg::STA: begin
                            // accumulator goes to ram at the mar
                            ctrl.bus_src   = cpu_ctrl_pkg::ACC;
                            ctrl.ram_write = 1'b1;
                        end
                        default: ctrl.bus_src = cpu_ctrl_pkg::NONE;
                    endcase
                end
                cpu_ctrl_pkg::T5: begin
                    if (opcode == cpu_isa_pkg::ADD || opcode == cpu_isa_pkg::SUB) begin
                        ctrl.bus_src    = cpu_ctrl_pkg::ALU;
                        ctrl.a_load     = 1'b1;
                        ctrl.flags_load = 1'b1;
                        ctrl.alu_sub    = (opcode == cpu_isa_pkg::SUB);
                    end
                end
                default: ;
            endcase
        end
    end

    a_tstate_onehot : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot(tstate)
    );

endmodule

// File: src/cpu_ctrl_pkg.sv
// control types of the accumulator cpu
// the decoder drives one control word and the top level fans it out
`include "cpu_params.svh"

package cpu_ctrl_pkg;

    // one-hot t-state, t0..t2 fetch, t3..t5 execute
    typedef enum logic [`CPU_T_STATES-1:0] {
        T0 = 6'b000001,
        T1 = 6'b000010,
        T2 = 6'b000100,
        T3 = 6'b001000,
        T4 = 6'b010000,
        T5 = 6'b100000
    } tstate_t;

    // which block drives the bus this cycle
    typedef enum logic [2:0] {
        NONE,
        PC,
        IR_OPERAND,
        RAM,
        ACC,
        ALU
    } bus_src_e;

    // all bits active high
    typedef struct packed {
        bus_src_e bus_src;
        logic     pc_count;
        logic     pc_load;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     a_load;
        logic     b_load;
        logic     alu_sub;
        logic     flags_load;
        logic     out_load;
        logic     halt;
    } ctrl_word_t;

endpackage

// File: src/cpu_isa_pkg.sv
// instruction set types of the accumulator cpu
// used by the datapath, the decoder and the testbench through scoped names
`include "cpu_params.svh"

package cpu_isa_pkg;

    // opcode fills what the operand leaves of the byte
    localparam int OPCODE_W = `CPU_DATA_W - `CPU_ADDR_W;

    // one data byte, as carried on the bus
    typedef logic [`CPU_DATA_W-1:0] byte_t;

    // ram or pc address
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // 9 to 13 unused, decoded as idle
    typedef enum logic [OPCODE_W-1:0] {
        NOP = 4'h0,
        LDA = 4'h1,
        ADD = 4'h2,
        SUB = 4'h3,
        STA = 4'h4,
        LDI = 4'h5,
        JMP = 4'h6,
        JC  = 4'h7,
        JZ  = 4'h8,
        OUT = 4'he,
        HLT = 4'hf
    } opcode_e;

    // opcode in the high nibble, operand in the low nibble
    typedef struct packed {
        opcode_e opcode;
        addr_t   operand;
    } instr_t;

endpackage

// File: src/cpu_top.sv
// top level of the sap-1 style accumulator cpu
// load a program through prog_we while run is low, then raise run
// out_value changes on each OUT, with out_strobe high for one cycle
`include "cpu_params.svh"

module cpu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               run,
    input  logic               prog_we,
    input  cpu_isa_pkg::addr_t prog_addr,
    input  cpu_isa_pkg::byte_t prog_data,
    output cpu_isa_pkg::byte_t out_value,
    output logic               out_strobe,
    output logic               halted
);

    cpu_ctrl_pkg::ctrl_word_t ctrl;
    cpu_isa_pkg::byte_t       bus;
    cpu_isa_pkg::addr_t       pc;
    cpu_isa_pkg::instr_t      ir;
    cpu_isa_pkg::byte_t       acc;
    cpu_isa_pkg::byte_t       b_reg;
    cpu_isa_pkg::byte_t       alu_result;
    cpu_isa_pkg::byte_t       ram_rd;
    logic                     carry;
    logic                     zero;

    // bus mux, replaces the tristate bus
    always_comb begin
        case (ctrl.bus_src)
            // nibble sources are zero extended
            cpu_ctrl_pkg::PC:         bus = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, pc};
            cpu_ctrl_pkg::IR_OPERAND: bus = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, ir.operand};
            cpu_ctrl_pkg::RAM:        bus = ram_rd;
            cpu_ctrl_pkg::ACC:        bus = acc;
            cpu_ctrl_pkg::ALU:        bus = alu_result;
            default:                  bus = '0;
        endcase
    end

    control_block u_control (
        .clk    (clk),
        .arst_n (arst_n),
        .run    (run),
        .opcode (ir.opcode),
        .carry  (carry),
        .zero   (zero),
        .ctrl   (ctrl),
        .halted (halted)
    );

    program_counter u_pc (
        .clk        (clk),
        .arst_n     (arst_n),
        .count      (ctrl.pc_count),
        .load       (ctrl.pc_load),
        .load_value (bus[`CPU_ADDR_W-1:0]),
        .pc         (pc)
    );

    ram_mar u_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .mar_load  (ctrl.mar_load),
        .write     (ctrl.ram_write),
        .bus_in    (bus),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_data   (ram_rd)
    );

    // instruction register, split into opcode and operand
    data_register #(.payload_t(cpu_isa_pkg::instr_t)) u_ir (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (ctrl.ir_load),
        .d      (cpu_isa_pkg::instr_t'(bus)),
        .q      (ir)
    );

    // accumulator
    data_register u_acc (.clk(clk), .arst_n(arst_n), .load(ctrl.a_load), .d(bus), .q(acc));

    // b register, second alu operand
    data_register u_b (.clk(clk), .arst_n(arst_n), .load(ctrl.b_load), .d(bus), .q(b_reg));

    // output register
    data_register u_out (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (ctrl.out_load),
        .d      (bus),
        .q      (out_value)
    );

    alu u_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .a          (acc),
        .b          (b_reg),
        .sub        (ctrl.alu_sub),
        .flags_load (ctrl.flags_load),
        .result     (alu_result),
        .carry      (carry),
        .zero       (zero)
    );

    // strobe lines up with the new out_value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= ctrl.out_load;
        end
    end

endmodule

// File: src/data_register.sv
// loadable register for any payload type
// serves as accumulator, b, output and instruction register
module data_register #(
    parameter type payload_t = cpu_isa_pkg::byte_t
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  payload_t d,
    output payload_t q
);

    // captures the bus on load, holds otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // all zero, also a nop for the instruction register
            q <= payload_t'('0);
        end else if (load) begin
            q <= d;
        end
    end

endmodule

// File: src/program_counter.sv
// program counter of the accumulator cpu
// counts through ram on fetch, loads a jump target from the bus
module program_counter (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               count,
    input  logic               load,
    input  cpu_isa_pkg::addr_t load_value,
    output cpu_isa_pkg::addr_t pc
);

    // execution always starts at address 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (load) begin
            // jump target from the operand nibble
            pc <= load_value;
        end else if (count) begin
            // wraps from 15 back to 0
            pc <= pc + 1'b1;
        end
    end

    // count is a fetch step and load an execute step
    // so the decoder must never raise both in one cycle
    a_no_count_and_load : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(count && load)
    );

endmodule

// File: src/ram_mar.sv
// memory address register and 16 byte ram
// cpu side reads and writes at the mar, programming writes at prog_addr
// programming is only legal while the cpu is stopped
`include "cpu_params.svh"

module ram_mar (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               mar_load,
    input  logic               write,
    input  cpu_isa_pkg::byte_t bus_in,
    input  logic               prog_we,
    input  cpu_isa_pkg::addr_t prog_addr,
    input  cpu_isa_pkg::byte_t prog_data,
    output cpu_isa_pkg::byte_t rd_data
);

    cpu_isa_pkg::addr_t mar;
    cpu_isa_pkg::byte_t mem [`CPU_RAM_DEPTH];

    // address comes from the low nibble of the bus
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar <= '0;
        end else if (mar_load) begin
            mar <= bus_in[`CPU_ADDR_W-1:0];
        end
    end

    // storage, one write port shared by both paths
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end else if (write) begin
            mem[mar] <= bus_in;
        end
    end

    // asynchronous read at the mar
    assign rd_data = mem[mar];

    // prog_we comes from outside and write from the decoder
    // both together means a program load while running
    a_no_prog_during_write : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(prog_we && write)
    );

endmodule

// File: tb.f
+incdir+include
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/program_counter.sv
src/control_block.sv
src/alu.sv
src/data_register.sv
src/ram_mar.sv
src/cpu_top.sv
verif/cpu_tb.sv

// File: verif/cpu_tb.sv
// directed testbench for the accumulator cpu
// each test loads a program, runs it up to HLT and compares the OUT values
// with a reference model of the instruction set and flag rules
`include "cpu_params.svh"

module cpu_tb;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_INSTR  = 64;
    // 5 directed runs plus 20 random runs
    localparam int RUNS       = 25;
    // reset, idle check, program load and the longest allowed program
    localparam int RUN_CYCLES = (MAX_INSTR + 4) * `CPU_T_STATES + 40;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               run;
    logic               prog_we;
    cpu_isa_pkg::addr_t prog_addr;
    cpu_isa_pkg::byte_t prog_data;
    cpu_isa_pkg::byte_t out_value;
    logic               out_strobe;
    logic               halted;

    cpu_isa_pkg::byte_t prog_mem [`CPU_RAM_DEPTH];
    cpu_isa_pkg::byte_t exp_vals [MAX_INSTR];
    int                 exp_cnt;
    int                 exp_instr;
    int                 errors    = 0;
    int                 checks    = 0;
    logic [31:0]        lcg_state = 32'd49461;

    cpu_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .out_value  (out_value),
        .out_strobe (out_strobe),
        .halted     (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // every run is bounded by MAX_INSTR instructions
    initial begin
        #((RUNS * RUN_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired, the CPU never halted");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic cpu_isa_pkg::byte_t encode(cpu_isa_pkg::opcode_e op,
                                                  cpu_isa_pkg::addr_t arg);
        return {op, arg};
    endfunction

    // unused bytes hold HLT with the address as operand
    function automatic void fill_with_hlt();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            prog_mem[i] = encode(cpu_isa_pkg::HLT, cpu_isa_pkg::addr_t'(i));
        end
    endfunction

    // isa rules applied to prog_mem, gives the OUT list and instruction count
    function automatic void predict_outputs();
        cpu_isa_pkg::byte_t mem [`CPU_RAM_DEPTH];
        cpu_isa_pkg::byte_t acc;
        cpu_isa_pkg::byte_t opnd;
        cpu_isa_pkg::addr_t pc;
        cpu_isa_pkg::addr_t arg;
        logic [3:0]         op;
        logic               carry;
        logic               zero;
        logic               done;
        acc       = '0;
        pc        = '0;
        carry     = 1'b0;
        zero      = 1'b0;
        done      = 1'b0;
        exp_cnt   = 0;
        exp_instr = 0;
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            mem[i] = prog_mem[i];
        end
        while (!done && exp_instr < MAX_INSTR) begin
            op   = mem[pc][7:4];
            arg  = mem[pc][3:0];
            opnd = mem[arg];
            pc   = pc + 1'b1;
            exp_instr++;
            case (op)
                cpu_isa_pkg::LDA: acc = opnd;
                cpu_isa_pkg::ADD: begin
                    // carry when the true sum reaches 256
                    carry = (int'(acc) + int'(opnd)) >= 256;
                    acc   = acc + opnd;
                    zero  = (acc == 8'h00);
                end
                cpu_isa_pkg::SUB: begin
                    // carry means no borrow
                    carry = (acc >= opnd);
                    acc   = acc - opnd;
                    zero  = (acc == 8'h00);
                end
                cpu_isa_pkg::STA: mem[arg] = acc;
                cpu_isa_pkg::LDI: acc = {4'h0, arg};
                cpu_isa_pkg::JMP: pc = arg;
                cpu_isa_pkg::JC:  if (carry) pc = arg;
                cpu_isa_pkg::JZ:  if (zero) pc = arg;
                cpu_isa_pkg::OUT: begin
                    exp_vals[exp_cnt] = acc;
                    exp_cnt++;
                end
                cpu_isa_pkg::HLT: done = 1'b1;
                default: ;
            endcase
        end
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        arst_n  <= 1'b0;
        run     <= 1'b0;
        prog_we <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // outputs stay quiet while run is low
    task automatic expect_idle(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checks++;
            assert (!out_strobe && !halted && out_value == 8'h00) else begin
                errors++;
                $display("ERR t=%0t out_strobe/halted/out_value expected 0/0/00 actual %0b/%0b/%02h",
                         $time, out_strobe, halted, out_value);
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cpu_isa_pkg::addr_t'(i);
            prog_data <= prog_mem[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // collects strobed outputs until halted, then compares with the model
    task automatic run_until_halt(string name);
        cpu_isa_pkg::byte_t got [MAX_INSTR];
        int                 got_cnt;
        int                 cycles;
        got_cnt = 0;
        cycles  = 0;
        @(posedge clk);
        run <= 1'b1;
        while (!halted && cycles < (exp_instr + 4) * `CPU_T_STATES) begin
            @(negedge clk);
            cycles++;
            if (out_strobe && got_cnt < MAX_INSTR) begin
                got[got_cnt] = out_value;
                got_cnt++;
            end
        end
        checks++;
        assert (halted) else begin
            errors++;
            $display("%s: the CPU did not halt within %0d cycles", name, cycles);
        end
        checks++;
        assert (got_cnt == exp_cnt) else begin
            errors++;
            $display("ERR t=%0t %s out_strobe count expected %0d actual %0d",
                     $time, name, exp_cnt, got_cnt);
        end
        for (int i = 0; i < exp_cnt && i < got_cnt; i++) begin
            checks++;
            assert (got[i] == exp_vals[i]) else begin
                errors++;
                $display("ERR t=%0t %s out_value[%0d] expected %02h actual %02h",
                         $time, name, i, exp_vals[i], got[i]);
            end
        end
    endtask

    task automatic execute_program(string name);
        apply_reset();
        expect_idle(3);
        load_program();
        predict_outputs();
        run_until_halt(name);
    endtask

    // run is still high, nothing may move after HLT
    task automatic verify_halt_sticky();
        repeat (5 * `CPU_T_STATES) begin
            @(negedge clk);
            checks++;
            assert (halted && !out_strobe) else begin
                errors++;
                $display("ERR t=%0t halted/out_strobe expected 1/0 actual %0b/%0b",
                         $time, halted, out_strobe);
            end
        end
    endtask

    // LDA, ADD/SUB, OUT, JC over a marker LDI/OUT, HLT
    function automatic void build_alu_program(cpu_isa_pkg::byte_t a_val,
                                              cpu_isa_pkg::byte_t b_val, logic do_sub);
        fill_with_hlt();
        prog_mem[0]  = encode(cpu_isa_pkg::LDA, 4'd14);
        prog_mem[1]  = encode(
            cpu_isa_pkg::opcode_e'(do_sub ? cpu_isa_pkg::SUB : cpu_isa_pkg::ADD), 4'd15);
        prog_mem[2]  = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[3]  = encode(cpu_isa_pkg::JC, 4'd6);
        prog_mem[4]  = encode(cpu_isa_pkg::LDI, 4'd10);
        prog_mem[5]  = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[14] = a_val;
        prog_mem[15] = b_val;
    endfunction

    task automatic add_sub_sequence();
        fill_with_hlt();
        prog_mem[0]  = encode(cpu_isa_pkg::LDA, 4'd14);
        prog_mem[1]  = encode(cpu_isa_pkg::ADD, 4'd15);
        prog_mem[2]  = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[3]  = encode(cpu_isa_pkg::SUB, 4'd13);
        prog_mem[4]  = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[5]  = encode(cpu_isa_pkg::ADD, 4'd12);
        prog_mem[6]  = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[12] = 8'h9c;
        prog_mem[13] = 8'h37;
        prog_mem[14] = 8'hc8;
        prog_mem[15] = 8'h64;
        execute_program("arithmetic");
    endtask

    task automatic store_and_reload();
        fill_with_hlt();
        prog_mem[0] = encode(cpu_isa_pkg::LDI, 4'd9);
        prog_mem[1] = encode(cpu_isa_pkg::STA, 4'd15);
        prog_mem[2] = encode(cpu_isa_pkg::LDI, 4'd0);
        prog_mem[3] = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[4] = encode(cpu_isa_pkg::LDA, 4'd15);
        prog_mem[5] = encode(cpu_isa_pkg::OUT, 4'd0);
        execute_program("memory");
        verify_halt_sticky();
    endtask

    // counts 6 down to 0 through JZ and JMP
    task automatic countdown_loop();
        fill_with_hlt();
        prog_mem[0] = encode(cpu_isa_pkg::LDI, 4'd1);
        prog_mem[1] = encode(cpu_isa_pkg::STA, 4'd15);
        prog_mem[2] = encode(cpu_isa_pkg::LDI, 4'd6);
        prog_mem[3] = encode(cpu_isa_pkg::OUT, 4'd0);
        prog_mem[4] = encode(cpu_isa_pkg::JZ, 4'd7);
        prog_mem[5] = encode(cpu_isa_pkg::SUB, 4'd15);
        prog_mem[6] = encode(cpu_isa_pkg::JMP, 4'd3);
        execute_program("countdown");
    endtask

    task automatic carry_branch();
        // carry set, marker skipped
        build_alu_program(8'd200, 8'd100, 1'b0);
        execute_program("jc add");
        // borrow, marker taken
        build_alu_program(8'd3, 8'd5, 1'b1);
        execute_program("jc sub");
    endtask

    task automatic random_operands();
        logic [31:0] r;
        repeat (20) begin
            r = lcg_next();
            build_alu_program(r[31:24], r[23:16], r[15]);
            execute_program("random");
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        add_sub_sequence();
        store_and_reload();
        countdown_loop();
        carry_branch();
        random_operands();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
